// ==== sq_defs.svh ====
`ifndef SQ_DEFS_SVH
`define SQ_DEFS_SVH

// Store queue depth
`define SQ_SIZE 8
`define SQ_IDX_W ($clog2(`SQ_SIZE))
`define SQ_CNT_W ($clog2(`SQ_SIZE) + 1)

// Physical register file, sets the tag width
`define PRF_SIZE 64
`define TAG_W ($clog2(`PRF_SIZE))

// ROB index carries one extra wrap bit
`define ROB_SIZE 32
`define ROB_IDX_W ($clog2(`ROB_SIZE) + 1)

// Operand and address width
`define XLEN 64

`endif

// ==== core_pkg.sv ====
`include "sq_defs.svh"

package core_pkg;

	// One store coming out of rename/dispatch
	typedef struct packed {
		logic                   valid;
		logic [`XLEN-1:0]       pc;
		logic [31:0]            inst;
		logic [`XLEN-1:0]       opa;        // Displacement
		logic [`XLEN-1:0]       opb;        // Base value or tag
		logic                   opb_valid;
		logic [`XLEN-1:0]       rega;       // Store data value or tag
		logic                   rega_valid;
		logic [`ROB_IDX_W-1:0]  rob_idx;
		logic [`TAG_W-1:0]      dest;
	} sq_dispatch_t;

	// One result broadcast on a common data bus
	typedef struct packed {
		logic                   valid;
		logic [`TAG_W-1:0]      tag;
		logic [`XLEN-1:0]       value;
	} cdb_t;

	// What a queue entry presents to the issue unit
	typedef struct packed {
		logic                   inuse;
		logic                   ready;      // Address and data both known
		logic                   requested;
		logic [`XLEN-1:0]       pc;
		logic [31:0]            inst;
		logic [`XLEN-1:0]       opa;
		logic [`XLEN-1:0]       opb;
		logic [`ROB_IDX_W-1:0]  rob_idx;
		logic [`XLEN-1:0]       data;
	} sq_entry_t;

endpackage

// ==== mem_pkg.sv ====
`include "sq_defs.svh"

package mem_pkg;

	// Store width, encoded in inst[27:26]
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2,
		SIZE_QUAD = 2'd3
	} store_size_e;

	// Issue unit FSM
	typedef enum logic [1:0] {
		ISSUE_IDLE    = 2'd0,
		ISSUE_REQUEST = 2'd1,       // Request held until mem_done
		ISSUE_RELEASE = 2'd2        // Free the head entry
	} issue_state_e;

	// Write request to the memory side
	typedef struct packed {
		logic                   valid;
		logic [`XLEN-1:0]       addr;
		logic [`XLEN-1:0]       data;
		store_size_e            size;
		logic [`ROB_IDX_W-1:0]  rob_idx;
	} mem_req_t;

endpackage

// ==== sq_one_entry.sv ====
`timescale 1ns/10ps
`include "sq_defs.svh"

module sq_one_entry (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  clean,
	input  logic                  write1,
	input  logic                  write2,
	input  logic                  request,
	input  logic                  free,
	input  core_pkg::sq_dispatch_t dispatch1,
	input  core_pkg::sq_dispatch_t dispatch2,
	input  core_pkg::cdb_t        cdb1,
	input  core_pkg::cdb_t        cdb2,
	output core_pkg::sq_entry_t   entry
);

	logic                   inuse;
	logic                   requested;
	logic                   addr_valid;     // opb holds the base value
	logic                   data_valid;     // data holds the store value
	logic [`XLEN-1:0]       pc;
	logic [31:0]            inst;
	logic [`XLEN-1:0]       opa;
	logic [`XLEN-1:0]       opb;
	logic [`ROB_IDX_W-1:0]  rob_idx;
	logic [`XLEN-1:0]       data;

	core_pkg::sq_dispatch_t src;
	logic                   load;
	logic                   wake_b1, wake_b2;
	logic                   wake_d1, wake_d2;

	assign load = write1 | write2;
	assign src  = write1 ? dispatch1 : dispatch2;   // write1 wins when both strobe

	// Tag match on either bus while the operand is still missing
	assign wake_b1 = inuse && !addr_valid && cdb1.valid && (opb[`TAG_W-1:0] == cdb1.tag);
	assign wake_b2 = inuse && !addr_valid && cdb2.valid && (opb[`TAG_W-1:0] == cdb2.tag);
	assign wake_d1 = inuse && !data_valid && cdb1.valid && (data[`TAG_W-1:0] == cdb1.tag);
	assign wake_d2 = inuse && !data_valid && cdb2.valid && (data[`TAG_W-1:0] == cdb2.tag);

	always_ff @(posedge clock) begin
		if (reset || clean) begin
			inuse      <= 1'b0;
			requested  <= 1'b0;
			addr_valid <= 1'b0;
			data_valid <= 1'b0;
		end else if (load) begin
			inuse      <= 1'b1;
			requested  <= 1'b0;
			addr_valid <= src.opb_valid;
			data_valid <= src.rega_valid;
		end else if (free) begin
			inuse      <= 1'b0;
			requested  <= 1'b0;
			addr_valid <= 1'b0;
			data_valid <= 1'b0;
		end else begin
			if (wake_b1 || wake_b2)
				addr_valid <= 1'b1;
			if (wake_d1 || wake_d2)
				data_valid <= 1'b1;
			if (request)
				requested <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			pc      <= src.pc;
			inst    <= src.inst;
			opa     <= src.opa;
			opb     <= src.opb;
			rob_idx <= src.rob_idx;
			data    <= src.rega;
		end else begin
			if (wake_b1)
				opb <= cdb1.value;
			else if (wake_b2)
				opb <= cdb2.value;
			if (wake_d1)
				data <= cdb1.value;
			else if (wake_d2)
				data <= cdb2.value;
		end
	end

	always_comb begin
		entry.inuse     = inuse;
		entry.ready     = inuse && addr_valid && data_valid;
		entry.requested = requested;
		entry.pc        = pc;
		entry.inst      = inst;
		entry.opa       = opa;
		entry.opb       = opb;
		entry.rob_idx   = rob_idx;
		entry.data      = data;
	end

endmodule

// ==== sq_alloc.sv ====
`timescale 1ns/10ps
`include "sq_defs.svh"

module sq_alloc (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  clean,
	input  logic                  dispatch1_valid,
	input  logic                  dispatch2_valid,
	input  logic                  release_head,
	output logic [`SQ_SIZE-1:0]   write1,
	output logic [`SQ_SIZE-1:0]   write2,
	output logic [`SQ_CNT_W-1:0]  free_slots,
	output logic                  full
);

	logic [`SQ_IDX_W-1:0]  tail;
	logic [`SQ_IDX_W-1:0]  tail_plus1;
	logic [`SQ_IDX_W-1:0]  tail_plus2;
	logic [`SQ_CNT_W-1:0]  count;       // Entries in use
	logic                  grant1, grant2;

	// Circular step over SQ_SIZE slots
	function automatic logic [`SQ_IDX_W-1:0] wrap_inc(input logic [`SQ_IDX_W-1:0] ptr);
		if (ptr == `SQ_IDX_W'(`SQ_SIZE - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign tail_plus1 = wrap_inc(tail);
	assign tail_plus2 = wrap_inc(tail_plus1);

	assign free_slots = `SQ_CNT_W'(`SQ_SIZE) - count;
	assign full       = (free_slots == '0);

	// Dispatches past the free count are dropped
	assign grant1 = dispatch1_valid && !clean && (free_slots != '0);
	assign grant2 = dispatch2_valid && !clean && (free_slots > `SQ_CNT_W'(grant1));

	always_comb begin
		write1 = '0;
		write2 = '0;
		if (grant1)
			write1[tail] = 1'b1;
		if (grant2)
			write2[grant1 ? tail_plus1 : tail] = 1'b1;   // Packs behind dispatch1
	end

	always_ff @(posedge clock) begin
		if (reset || clean) begin
			tail  <= '0;
			count <= '0;
		end else begin
			if (grant1 && grant2)
				tail <= tail_plus2;
			else if (grant1 || grant2)
				tail <= tail_plus1;
			count <= count + `SQ_CNT_W'(grant1) + `SQ_CNT_W'(grant2)
				- `SQ_CNT_W'(release_head);
		end
	end

endmodule

// ==== sq_issue.sv ====
`timescale 1ns/10ps
`include "sq_defs.svh"

module sq_issue (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 clean,
	input  logic                 mem_done,
	input  core_pkg::sq_entry_t  entries [`SQ_SIZE],
	output logic [`SQ_SIZE-1:0]  request,
	output logic [`SQ_SIZE-1:0]  free,
	output logic                 release_head,
	output mem_pkg::mem_req_t    mem_req
);

	mem_pkg::issue_state_e  state;
	logic [`SQ_IDX_W-1:0]   head;
	core_pkg::sq_entry_t    head_entry;
	logic                   issue_go;

	assign head_entry = entries[head];

	// Oldest entry goes out once both operands are in
	assign issue_go = (state == mem_pkg::ISSUE_IDLE) && !clean
		&& head_entry.ready && !head_entry.requested;

	assign release_head = (state == mem_pkg::ISSUE_RELEASE) && !clean;

	always_comb begin
		request = '0;
		free    = '0;
		if (issue_go)
			request[head] = 1'b1;     // Marks the entry as sent
		if (release_head)
			free[head] = 1'b1;
	end

	always_ff @(posedge clock) begin
		if (reset || clean) begin
			state         <= mem_pkg::ISSUE_IDLE;
			head          <= '0;
			mem_req.valid <= 1'b0;   // Outstanding request is dropped
		end else begin
			unique case (state)
				mem_pkg::ISSUE_IDLE: begin
					if (issue_go) begin
						state         <= mem_pkg::ISSUE_REQUEST;
						mem_req.valid <= 1'b1;
					end
				end
				mem_pkg::ISSUE_REQUEST: begin
					if (mem_done) begin
						state         <= mem_pkg::ISSUE_RELEASE;
						mem_req.valid <= 1'b0;
					end
				end
				mem_pkg::ISSUE_RELEASE: begin
					state <= mem_pkg::ISSUE_IDLE;
					head  <= (head == `SQ_IDX_W'(`SQ_SIZE - 1)) ? '0 : head + 1'b1;
				end
				default: state <= mem_pkg::ISSUE_IDLE;
			endcase
		end

		// Request payload is captured once and held
		if (issue_go) begin
			mem_req.addr    <= head_entry.opa + head_entry.opb;
			mem_req.data    <= head_entry.data;
			mem_req.size    <= mem_pkg::store_size_e'(head_entry.inst[27:26]);
			mem_req.rob_idx <= head_entry.rob_idx;
		end
	end

endmodule

// ==== store_queue.sv ====
`timescale 1ns/10ps
`include "sq_defs.svh"

module store_queue (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   clean,
	input  core_pkg::sq_dispatch_t dispatch1,
	input  core_pkg::sq_dispatch_t dispatch2,
	input  core_pkg::cdb_t         cdb1,
	input  core_pkg::cdb_t         cdb2,
	input  logic                   mem_done,
	output mem_pkg::mem_req_t      mem_req,
	output logic [`SQ_CNT_W-1:0]   free_slots,
	output logic                   full
);

	logic [`SQ_SIZE-1:0]  write1, write2;   // One-hot allocation strobes
	logic [`SQ_SIZE-1:0]  request, free;
	logic                 release_head;
	core_pkg::sq_entry_t  entries [`SQ_SIZE];

	sq_alloc u_alloc (
		.clock           (clock),
		.reset           (reset),
		.clean           (clean),
		.dispatch1_valid (dispatch1.valid),
		.dispatch2_valid (dispatch2.valid),
		.release_head    (release_head),
		.write1          (write1),
		.write2          (write2),
		.free_slots      (free_slots),
		.full            (full)
	);

	for (genvar gi = 0; gi < `SQ_SIZE; gi++) begin : g_entry
		sq_one_entry u_entry (
			.clock     (clock),
			.reset     (reset),
			.clean     (clean),
			.write1    (write1[gi]),
			.write2    (write2[gi]),
			.request   (request[gi]),
			.free      (free[gi]),
			.dispatch1 (dispatch1),
			.dispatch2 (dispatch2),
			.cdb1      (cdb1),
			.cdb2      (cdb2),
			.entry     (entries[gi])
		);
	end

	sq_issue u_issue (
		.clock        (clock),
		.reset        (reset),
		.clean        (clean),
		.mem_done     (mem_done),
		.entries      (entries),
		.request      (request),
		.free         (free),
		.release_head (release_head),
		.mem_req      (mem_req)
	);

endmodule

// ==== store_queue_chk.sv ====
`timescale 1ns/10ps
`include "sq_defs.svh"

module store_queue_chk (
	input logic                  clock,
	input logic                  reset,
	input logic                  clean,
	input logic                  mem_done,
	input mem_pkg::mem_req_t     mem_req,
	input logic [`SQ_CNT_W-1:0]  free_slots,
	input logic                  full
);

	int assert_errors = 0;      // Failed assertions so far

	// Request held steady until memory acknowledges
	req_stable: assert property (@(posedge clock)
		!reset && !clean && mem_req.valid && !mem_done |=> $stable(mem_req))
		else begin
			$error("mem_req changed before mem_done");
			assert_errors++;
		end

	clean_drops: assert property (@(posedge clock) disable iff (reset)
		clean |=> !mem_req.valid)
		else begin
			$error("mem_req.valid high in the cycle after clean");
			assert_errors++;
		end

	slots_bound: assert property (@(posedge clock) disable iff (reset)
		free_slots <= `SQ_CNT_W'(`SQ_SIZE))
		else begin
			$error("free_slots above the queue size");
			assert_errors++;
		end

	full_match: assert property (@(posedge clock) disable iff (reset)
		full == (free_slots == '0))
		else begin
			$error("full does not match an empty free count");
			assert_errors++;
		end

endmodule

bind store_queue store_queue_chk chk_i (
	.clock      (clock),
	.reset      (reset),
	.clean      (clean),
	.mem_done   (mem_done),
	.mem_req    (mem_req),
	.free_slots (free_slots),
	.full       (full)
);

// ==== store_queue_tb.sv ====
`timescale 1ns/10ps
`include "sq_defs.svh"

module store_queue_tb;

	localparam int WAIT_LIMIT  = 200;
	localparam int DRAIN_LIMIT = 800;

	logic                   clock;
	logic                   reset;
	logic                   clean;
	logic                   mem_done;
	core_pkg::sq_dispatch_t dispatch1, dispatch2;
	core_pkg::cdb_t         cdb1, cdb2;
	mem_pkg::mem_req_t      mem_req;
	logic [`SQ_CNT_W-1:0]   free_slots;
	logic                   full;

	logic [31:0]            lfsr = 32'h67b8_5db7;
	int                     errors = 0;
	int                     ref_used = 0;         // Occupancy per the reference
	int                     flush_count = 0;
	logic                   rel_pending = 1'b0;   // Head frees on the next edge
	logic                   long_delay;
	logic                   grant1, grant2;
	logic [`TAG_W-1:0]      next_tag = '0;
	logic [`ROB_IDX_W-1:0]  next_rob = '0;
	mem_pkg::mem_req_t      exp1, exp2;           // Expected request per dispatch lane
	mem_pkg::mem_req_t      exp_q [$];            // Accepted stores with the oldest first
	core_pkg::cdb_t         bcast_q [$];          // Tag values still to broadcast

	store_queue store_queue_i (
		.clock      (clock),
		.reset      (reset),
		.clean      (clean),
		.dispatch1  (dispatch1),
		.dispatch2  (dispatch2),
		.cdb1       (cdb1),
		.cdb2       (cdb2),
		.mem_done   (mem_done),
		.mem_req    (mem_req),
		.free_slots (free_slots),
		.full       (full)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[62:0], fb};
		end
		return r;
	endfunction

	function automatic logic rand_bit();
		return 1'(rand_bits(1));
	endfunction

	function automatic mem_pkg::mem_req_t expected_request(input logic [`XLEN-1:0] disp,
			input logic [`XLEN-1:0] base, input logic [`XLEN-1:0] value,
			input logic [31:0] inst, input logic [`ROB_IDX_W-1:0] rob_idx);
		mem_pkg::mem_req_t r;
		r.valid   = 1'b1;
		r.addr    = disp + base;
		r.data    = value;
		r.rob_idx = rob_idx;
		case (inst[27:26])
			2'd0:    r.size = mem_pkg::SIZE_BYTE;
			2'd1:    r.size = mem_pkg::SIZE_HALF;
			2'd2:    r.size = mem_pkg::SIZE_WORD;
			default: r.size = mem_pkg::SIZE_QUAD;
		endcase
		return r;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] want);
		if (got !== want) begin
			errors++;
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, want);
		end
	endtask

	task automatic finish_run();
		int asserts;
		asserts = store_queue_i.chk_i.assert_errors;
		$display("Closing report: %0d check errors, %0d assertion failures", errors, asserts);
		if (errors == 0 && asserts == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	endtask

	task automatic make_store(input logic tag_mode, output core_pkg::sq_dispatch_t d,
			output mem_pkg::mem_req_t e);
		logic [`XLEN-1:0] base;
		logic [`XLEN-1:0] value;
		d         = '0;
		d.valid   = 1'b1;
		d.pc      = rand_bits(64);
		d.inst    = 32'(rand_bits(32));
		d.opa     = rand_bits(12);        // Small displacement
		d.dest    = `TAG_W'(rand_bits(`TAG_W));
		d.rob_idx = next_rob;
		next_rob  = next_rob + 1'b1;
		base      = rand_bits(64);
		value     = rand_bits(64);
		e         = expected_request(d.opa, base, value, d.inst, d.rob_idx);
		d.opb_valid = !(tag_mode && rand_bit());
		d.opb       = d.opb_valid ? base : `XLEN'(next_tag);
		if (!d.opb_valid) begin
			bcast_q.push_back({1'b1, next_tag, base});
			next_tag = next_tag + 1'b1;
		end
		d.rega_valid = !(tag_mode && rand_bit());
		d.rega       = d.rega_valid ? value : `XLEN'(next_tag);
		if (!d.rega_valid) begin
			bcast_q.push_back({1'b1, next_tag, value});
			next_tag = next_tag + 1'b1;
		end
	endtask

	// One clock of stimulus where tags queued now go out from the next cycle on
	task automatic drive_cycle(input logic en1, input logic en2, input logic tag_mode);
		core_pkg::sq_dispatch_t d1, d2;
		mem_pkg::mem_req_t      e1, e2;
		core_pkg::cdb_t         b1, b2;
		@(posedge clock);
		d1 = '0;
		d2 = '0;
		e1 = '0;
		e2 = '0;
		b1 = '0;
		b2 = '0;
		if (bcast_q.size() != 0) begin
			if (rand_bit())
				b1 = bcast_q.pop_front();
			else
				b2 = bcast_q.pop_front();
		end
		if (bcast_q.size() != 0 && rand_bit()) begin
			if (b1.valid)
				b2 = bcast_q.pop_front();
			else
				b1 = bcast_q.pop_front();
		end
		if (en1)
			make_store(tag_mode, d1, e1);
		if (en2)
			make_store(tag_mode, d2, e2);
		dispatch1 <= d1;
		dispatch2 <= d2;
		exp1      <= e1;
		exp2      <= e2;
		cdb1      <= b1;
		cdb2      <= b2;
	endtask

	task automatic drain_queue();
		int waited;
		waited = 0;
		do begin
			drive_cycle(1'b0, 1'b0, 1'b0);
			@(negedge clock);
			waited++;
			if (waited > DRAIN_LIMIT) begin
				$display("Timeout: the store queue did not drain");
				errors++;
				finish_run();
			end
		end while (ref_used != 0 || exp_q.size() != 0 || mem_req.valid);
	endtask

	// Reference allocator with grants limited by the free count
	always @(posedge clock) begin
		if (reset || clean) begin
			if (clean)
				flush_count++;
			ref_used    = 0;
			rel_pending = 1'b0;
			exp_q.delete();
		end else begin
			grant1 = dispatch1.valid && (ref_used < `SQ_SIZE);
			grant2 = dispatch2.valid && (ref_used + int'(grant1) < `SQ_SIZE);
			if (grant1)
				exp_q.push_back(exp1);
			if (grant2)
				exp_q.push_back(exp2);
			ref_used    = ref_used + int'(grant1) + int'(grant2) - int'(rel_pending);
			rel_pending = mem_done;   // Only pulsed for an outstanding request
		end
	end

	always @(negedge clock) begin
		if (!reset) begin
			check_value("free_slots", 64'(free_slots), 64'(`SQ_SIZE - ref_used));
			check_value("full", 64'(full), 64'(ref_used == `SQ_SIZE));
		end
	end

	// Compare each request with the oldest expected store and acknowledge it
	initial begin
		int                idle;
		int                delay;
		int                flushes;
		mem_pkg::mem_req_t want;
		forever begin
			idle = 0;
			@(negedge clock);
			while (!mem_req.valid) begin
				if (exp_q.size() != 0)
					idle++;
				if (idle > WAIT_LIMIT) begin
					$display("Timeout: no memory request while stores are pending");
					errors++;
					finish_run();
				end
				@(negedge clock);
			end
			flushes = flush_count;
			if (exp_q.size() == 0) begin
				$display("A memory request appeared with no store expected");
				errors++;
			end else begin
				want = exp_q.pop_front();
				check_value("mem_req.addr", mem_req.addr, want.addr);
				check_value("mem_req.data", mem_req.data, want.data);
				check_value("mem_req.size", 64'(mem_req.size), 64'(want.size));
				check_value("mem_req.rob_idx", 64'(mem_req.rob_idx), 64'(want.rob_idx));
			end
			delay = long_delay ? 16 + int'(rand_bits(3)) : int'(rand_bits(2));
			repeat (delay) @(negedge clock);
			if (flushes == flush_count) begin   // A flushed request gets no ack
				@(posedge clock);
				mem_done <= 1'b1;
				@(posedge clock);
				mem_done <= 1'b0;
			end
		end
	end

	initial begin
		int waited;
		reset      = 1'b1;
		clean      = 1'b0;
		mem_done   = 1'b0;
		dispatch1  = '0;
		dispatch2  = '0;
		cdb1       = '0;
		cdb2       = '0;
		exp1       = '0;
		exp2       = '0;
		long_delay = 1'b0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;

		repeat (10) drive_cycle(rand_bit(), 1'b0, 1'b0);   // Known operands in order
		drain_queue();
		repeat (10) drive_cycle(1'b1, rand_bit(), 1'b1);   // Operands woken by the CDBs
		drain_queue();
		long_delay = 1'b1;                                  // Back-pressure until full
		repeat (14) drive_cycle(1'b1, 1'b1, rand_bit());
		drain_queue();

		// Flush with a request outstanding
		repeat (3) drive_cycle(1'b1, 1'b1, 1'b0);
		waited = 0;
		while (!mem_req.valid) begin
			drive_cycle(1'b0, 1'b0, 1'b0);
			@(negedge clock);
			waited++;
			if (waited > WAIT_LIMIT) begin
				$display("Timeout: no request before the flush");
				errors++;
				finish_run();
			end
		end
		@(posedge clock);
		clean <= 1'b1;
		@(posedge clock);
		clean <= 1'b0;
		@(negedge clock);
		check_value("mem_req.valid", 64'(mem_req.valid), 64'(0));
		check_value("free_slots", 64'(free_slots), 64'(`SQ_SIZE));
		long_delay = 1'b0;
		repeat (6) drive_cycle(1'b1, 1'b1, 1'b1);
		drain_queue();
		finish_run();
	end

endmodule

// ==== flist.f ====
+incdir+.
core_pkg.sv
mem_pkg.sv
sq_one_entry.sv
sq_alloc.sv
sq_issue.sv
store_queue.sv
store_queue_chk.sv
store_queue_tb.sv

// ==== run.sh ====
#!/bin/bash
# Build the store queue testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -f flist.f --top-module store_queue_tb -o store_queue_sim \
	&& ./obj_dir/store_queue_sim +verilator+error+limit+100 | tee /dev/stderr \
	| grep -q "Testbench passed" \
	&& echo "Simulation PASS" \
	|| { echo "Simulation FAIL"; exit 1; }
